/* verilog/ads_pkg.sv */
// ADS124x controller package
// Widths, SPI timing, ADC command words and FSM encodings

package ads_pkg;

    // ========================================
    // Timing
    // ========================================

    // aclk cycles per second, kept small for simulation
    localparam int ticks_per_second = 1000;
    // aclk cycles per SCLK half period
    localparam int spi_half_period  = 4;

    // ========================================
    // Vector types
    // ========================================

    typedef logic [23:0] ts_t;
    typedef logic [7:0]  spi_byte_t;
    typedef logic [31:0] spi_word_t;
    // Byte count minus one
    typedef logic [1:0]  nbytes_t;
    // Timestamp on top, response word below
    typedef logic [55:0] adc_word_t;

    // ========================================
    // ADC commands
    // ========================================

    localparam logic [23:0] cmd_mux_ch0   = 24'h400017;
    localparam logic [23:0] cmd_mux_ch1   = 24'h400008;
    localparam logic [23:0] cmd_noop_read = 24'hFFFFFF;
    // All auto commands are three bytes long
    localparam nbytes_t     nbytes_cmd    = 2'd2;

    typedef enum logic [2:0] {
        tx_rst, tx_idle, tx_byte3, tx_byte2, tx_byte1, tx_byte0
    } tx_state_e;

    typedef enum logic [2:0] {
        rx_rst, rx_idle, rx_byte3, rx_byte2, rx_byte1, rx_byte0
    } rx_state_e;

    typedef enum logic [2:0] {
        auto_rst, auto_idle, auto_ch0, auto_wait0, auto_ch1, auto_wait1
    } auto_state_e;

endpackage

/* verilog/ads_pps_timer.sv */
// PPS aligned second timer
// Counts aclk cycles within the second and emits the two
// half-second sample ticks for the auto sequence

`timescale 1ns/1ns

module ads_pps_timer (
    input  logic         aclk,
    input  logic         aresetn,
    input  logic         pps,
    output ads_pkg::ts_t timestamp,
    output logic         tick_a,
    output logic         tick_b
);

    ads_pkg::ts_t counter;

    // Preset to the last count so PPS wraps it to zero next cycle
    always_ff @(posedge aclk) begin
        if (!aresetn || pps) begin
            counter <= ads_pkg::ts_t'(ads_pkg::ticks_per_second - 1);
        end else if (counter == ads_pkg::ts_t'(ads_pkg::ticks_per_second - 1)) begin
            counter <= '0;
        end else begin
            counter <= counter + 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            tick_a <= 1'b0;
            tick_b <= 1'b0;
        end else begin
            tick_a <= (counter == ads_pkg::ts_t'(1));
            tick_b <= (counter == ads_pkg::ts_t'(ads_pkg::ticks_per_second / 2 + 1));
        end
    end

    assign timestamp = counter;

endmodule

/* verilog/ads_spi_master.sv */
// SPI mode 1 byte engine
// Full duplex, MSB first: MOSI launched on rising SCLK, MISO sampled on
// falling SCLK. CS is held across a command until its last byte is done.

`timescale 1ns/1ns

module ads_spi_master (
    input  logic               aclk,
    input  logic               aresetn,
    input  ads_pkg::spi_byte_t tx_data,
    input  logic               tx_valid,
    input  logic               tx_last,
    output logic               tx_ready,
    output ads_pkg::spi_byte_t rx_data,
    output logic               rx_valid,
    output logic               sclk,
    output logic               mosi,
    output logic               cs_n,
    input  logic               miso
);

    logic [$clog2(ads_pkg::spi_half_period)-1:0] div_cnt;
    logic [3:0]                                  half_cnt;
    ads_pkg::spi_byte_t                          shreg;
    logic                                        busy;
    logic                                        release_cs;
    logic                                        last_byte;
    logic                                        div_tick;
    logic                                        accept;

    assign div_tick = (div_cnt == $bits(div_cnt)'(ads_pkg::spi_half_period - 1));
    assign accept   = tx_valid && tx_ready;
    // Ready once the byte is done and CS is settled
    assign tx_ready = !busy && !release_cs;

    // ========================================
    // Pin and handshake control
    // ========================================

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            busy       <= 1'b0;
            release_cs <= 1'b0;
            cs_n       <= 1'b1;
            sclk       <= 1'b0;
            mosi       <= 1'b0;
            rx_valid   <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (accept) begin
                busy <= 1'b1;
                cs_n <= 1'b0;
            end else if (busy && div_tick) begin
                // Even half periods end on a rising edge
                sclk <= ~half_cnt[0];
                if (!half_cnt[0]) begin
                    mosi <= shreg[7];
                end
                if (half_cnt == 4'd15) begin
                    busy       <= 1'b0;
                    release_cs <= last_byte;
                    rx_valid   <= 1'b1;
                end
            end else if (release_cs && div_tick) begin
                release_cs <= 1'b0;
                cs_n       <= 1'b1;
            end
        end
    end

    // ========================================
    // Divider, bit counter and shift register
    // ========================================

    always_ff @(posedge aclk) begin
        if (accept) begin
            shreg     <= tx_data;
            last_byte <= tx_last;
            div_cnt   <= '0;
            half_cnt  <= '0;
        end else if (busy || release_cs) begin
            div_cnt <= div_tick ? '0 : div_cnt + 1'b1;
            if (busy && div_tick) begin
                half_cnt <= half_cnt + 1'b1;
                // Falling edge shifts MISO in behind the sent bit
                if (half_cnt[0]) begin
                    shreg <= {shreg[6:0], miso};
                end
                if (half_cnt == 4'd15) begin
                    rx_data <= {shreg[6:0], miso};
                end
            end
        end
    end

endmodule

/* verilog/ads_ctrl.sv */
// ADS124x command sequencer
// Runs host commands in manual mode, or the two-channel MUX write and
// DRDY-triggered read cycle in auto mode, and splits each command into
// SPI bytes. Results go to the host response or the sample stream.

`timescale 1ns/1ns

module ads_ctrl (
    input  logic               aclk,
    input  logic               aresetn,
    input  ads_pkg::ts_t       timestamp,
    input  logic               tick_a,
    input  logic               tick_b,
    output ads_pkg::spi_byte_t tx_data,
    output logic               tx_valid,
    output logic               tx_last,
    input  logic               tx_ready,
    input  ads_pkg::spi_byte_t rx_data,
    input  logic               rx_valid,
    input  logic               drdy_n,
    output logic               adc_start,
    output logic               adc_reset_n,
    input  logic               op_auto,
    input  logic               man_start,
    input  logic               man_reset_n,
    input  ads_pkg::spi_word_t cmd_data,
    input  ads_pkg::nbytes_t   cmd_nbytes,
    input  logic               cmd_valid,
    output logic               drdy_status,
    output ads_pkg::spi_word_t rsp_data,
    output logic               rsp_valid,
    output ads_pkg::adc_word_t sample_data,
    output logic               sample_valid,
    input  logic               sample_ready
);

    ads_pkg::tx_state_e   tx_state, tx_next;
    ads_pkg::rx_state_e   rx_state, rx_next;
    ads_pkg::auto_state_e auto_state, auto_next;

    ads_pkg::spi_word_t pend_data;
    ads_pkg::nbytes_t   pend_nbytes;
    logic               pend_valid;
    logic               pend_read;
    logic               cur_read;
    ads_pkg::spi_word_t tx_sr;
    logic [31:8]        rx_buf;
    ads_pkg::spi_word_t rx_word;
    logic [23:0]        auto_cmd;
    logic               drdy_s1, drdy_s2, drdy_s3;
    logic               drdy_fall;
    logic               auto_read, auto_load, host_load;
    logic               start, rx_done;

    // ========================================
    // ADC pins and DRDY synchronizer
    // ========================================

    assign adc_start   = op_auto ? 1'b1 : man_start;
    assign adc_reset_n = op_auto ? 1'b1 : man_reset_n;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            drdy_s1 <= 1'b1;
            drdy_s2 <= 1'b1;
            drdy_s3 <= 1'b1;
        end else begin
            drdy_s1 <= drdy_n;
            drdy_s2 <= drdy_s1;
            drdy_s3 <= drdy_s2;
        end
    end

    // Edge taken from the synchronized copy only
    assign drdy_fall   = drdy_s3 && !drdy_s2;
    assign drdy_status = drdy_s2;

    // ========================================
    // Auto sequence and pending command
    // ========================================

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            auto_state <= ads_pkg::auto_rst;
        end else begin
            auto_state <= auto_next;
        end
    end

    always_comb begin
        auto_next = auto_state;
        case (auto_state)
            ads_pkg::auto_rst:   auto_next = ads_pkg::auto_idle;
            ads_pkg::auto_idle:  if (op_auto && tick_a) auto_next = ads_pkg::auto_ch0;
            ads_pkg::auto_ch0:   auto_next = ads_pkg::auto_wait0;
            ads_pkg::auto_wait0: begin
                if (!op_auto) auto_next = ads_pkg::auto_idle;
                else if (tick_b) auto_next = ads_pkg::auto_ch1;
            end
            ads_pkg::auto_ch1:   auto_next = ads_pkg::auto_wait1;
            ads_pkg::auto_wait1: begin
                if (!op_auto) auto_next = ads_pkg::auto_idle;
                else if (tick_a) auto_next = ads_pkg::auto_ch0;
            end
            default:             auto_next = ads_pkg::auto_rst;
        endcase
    end

    assign auto_read = drdy_fall && (auto_state == ads_pkg::auto_wait0 ||
                                     auto_state == ads_pkg::auto_wait1);
    assign auto_load = auto_read || auto_state == ads_pkg::auto_ch0 ||
                       auto_state == ads_pkg::auto_ch1;
    assign host_load = !op_auto && cmd_valid;
    assign auto_cmd  = auto_read ? ads_pkg::cmd_noop_read :
                       (auto_state == ads_pkg::auto_ch0) ? ads_pkg::cmd_mux_ch0 :
                       ads_pkg::cmd_mux_ch1;

    // Command waits here until both byte machines are idle
    assign start = pend_valid && tx_state == ads_pkg::tx_idle &&
                   rx_state == ads_pkg::rx_idle;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            pend_valid <= 1'b0;
        end else if (auto_load || host_load) begin
            pend_valid <= 1'b1;
        end else if (start) begin
            pend_valid <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (auto_load) begin
            pend_data   <= {8'h00, auto_cmd};
            pend_nbytes <= ads_pkg::nbytes_cmd;
            pend_read   <= auto_read;
        end else if (host_load) begin
            pend_data   <= cmd_data;
            pend_nbytes <= cmd_nbytes;
            pend_read   <= 1'b0;
        end
    end

    // ========================================
    // TX and RX byte machines
    // ========================================

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            tx_state <= ads_pkg::tx_rst;
            rx_state <= ads_pkg::rx_rst;
        end else begin
            tx_state <= tx_next;
            rx_state <= rx_next;
        end
    end

    always_comb begin
        tx_next = tx_state;
        case (tx_state)
            ads_pkg::tx_rst:   tx_next = ads_pkg::tx_idle;
            ads_pkg::tx_idle: begin
                if (start) begin
                    case (pend_nbytes)
                        2'd3:    tx_next = ads_pkg::tx_byte3;
                        2'd2:    tx_next = ads_pkg::tx_byte2;
                        2'd1:    tx_next = ads_pkg::tx_byte1;
                        default: tx_next = ads_pkg::tx_byte0;
                    endcase
                end
            end
            ads_pkg::tx_byte3: if (tx_ready) tx_next = ads_pkg::tx_byte2;
            ads_pkg::tx_byte2: if (tx_ready) tx_next = ads_pkg::tx_byte1;
            ads_pkg::tx_byte1: if (tx_ready) tx_next = ads_pkg::tx_byte0;
            ads_pkg::tx_byte0: if (tx_ready) tx_next = ads_pkg::tx_idle;
            default:           tx_next = ads_pkg::tx_rst;
        endcase
    end

    always_comb begin
        rx_next = rx_state;
        case (rx_state)
            ads_pkg::rx_rst:   rx_next = ads_pkg::rx_idle;
            ads_pkg::rx_idle: begin
                if (start) begin
                    case (pend_nbytes)
                        2'd3:    rx_next = ads_pkg::rx_byte3;
                        2'd2:    rx_next = ads_pkg::rx_byte2;
                        2'd1:    rx_next = ads_pkg::rx_byte1;
                        default: rx_next = ads_pkg::rx_byte0;
                    endcase
                end
            end
            ads_pkg::rx_byte3: if (rx_valid) rx_next = ads_pkg::rx_byte2;
            ads_pkg::rx_byte2: if (rx_valid) rx_next = ads_pkg::rx_byte1;
            ads_pkg::rx_byte1: if (rx_valid) rx_next = ads_pkg::rx_byte0;
            ads_pkg::rx_byte0: if (rx_valid) rx_next = ads_pkg::rx_idle;
            default:           rx_next = ads_pkg::rx_rst;
        endcase
    end

    // First byte of a short command lands in the top of the shifter
    always_ff @(posedge aclk) begin
        if (start) begin
            tx_sr    <= pend_data << {~pend_nbytes, 3'b000};
            cur_read <= pend_read;
        end else if (tx_valid && tx_ready) begin
            tx_sr <= tx_sr << 8;
        end
    end

    assign tx_data  = tx_sr[31:24];
    assign tx_valid = tx_state == ads_pkg::tx_byte3 || tx_state == ads_pkg::tx_byte2 ||
                      tx_state == ads_pkg::tx_byte1 || tx_state == ads_pkg::tx_byte0;
    assign tx_last  = tx_state == ads_pkg::tx_byte0;

    // Cleared per command so short replies are zero-extended
    always_ff @(posedge aclk) begin
        if (start) begin
            rx_buf <= '0;
        end else if (rx_valid) begin
            case (rx_state)
                ads_pkg::rx_byte3: rx_buf[31:24] <= rx_data;
                ads_pkg::rx_byte2: rx_buf[23:16] <= rx_data;
                ads_pkg::rx_byte1: rx_buf[15:8]  <= rx_data;
                default:           rx_buf        <= rx_buf;
            endcase
        end
    end

    assign rx_done = rx_state == ads_pkg::rx_byte0 && rx_valid;
    assign rx_word = {rx_buf, rx_data};

    // ========================================
    // Host response and sample stream
    // ========================================

    always_ff @(posedge aclk) begin
        if (!aresetn || host_load) begin
            rsp_valid <= 1'b0;
            rsp_data  <= '0;
        end else if (rx_done && !op_auto) begin
            rsp_valid <= 1'b1;
            rsp_data  <= rx_word;
        end else if (op_auto) begin
            rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            sample_valid <= 1'b0;
        end else if (rx_done && cur_read) begin
            sample_valid <= 1'b1;
        end else if (sample_ready) begin
            sample_valid <= 1'b0;
        end
    end

    // A newer read replaces a sample still waiting for ready
    always_ff @(posedge aclk) begin
        if (rx_done && cur_read) begin
            sample_data <= {timestamp, rx_word};
        end
    end

endmodule

/* verilog/ads_top.sv */
// ADS124x controller top level
// PPS timer, command sequencer and SPI master

`timescale 1ns/1ns

module ads_top (
    input  logic               aclk,
    input  logic               aresetn,
    output logic               sclk,
    output logic               mosi,
    input  logic               miso,
    output logic               cs_n,
    output logic               adc_reset_n,
    output logic               adc_start,
    input  logic               drdy_n,
    input  logic               pps,
    input  logic               op_auto,
    input  logic               man_start,
    input  logic               man_reset_n,
    input  ads_pkg::spi_word_t cmd_data,
    input  ads_pkg::nbytes_t   cmd_nbytes,
    input  logic               cmd_valid,
    output logic               drdy_status,
    output ads_pkg::spi_word_t rsp_data,
    output logic               rsp_valid,
    output ads_pkg::adc_word_t sample_data,
    output logic               sample_valid,
    input  logic               sample_ready
);

    ads_pkg::ts_t       timestamp;
    logic               tick_a;
    logic               tick_b;
    ads_pkg::spi_byte_t tx_data;
    logic               tx_valid;
    logic               tx_last;
    logic               tx_ready;
    ads_pkg::spi_byte_t rx_data;
    logic               rx_valid;

    ads_pps_timer timer_i (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .pps       (pps),
        .timestamp (timestamp),
        .tick_a    (tick_a),
        .tick_b    (tick_b)
    );

    ads_ctrl ctrl_i (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .timestamp    (timestamp),
        .tick_a       (tick_a),
        .tick_b       (tick_b),
        .tx_data      (tx_data),
        .tx_valid     (tx_valid),
        .tx_last      (tx_last),
        .tx_ready     (tx_ready),
        .rx_data      (rx_data),
        .rx_valid     (rx_valid),
        .drdy_n       (drdy_n),
        .adc_start    (adc_start),
        .adc_reset_n  (adc_reset_n),
        .op_auto      (op_auto),
        .man_start    (man_start),
        .man_reset_n  (man_reset_n),
        .cmd_data     (cmd_data),
        .cmd_nbytes   (cmd_nbytes),
        .cmd_valid    (cmd_valid),
        .drdy_status  (drdy_status),
        .rsp_data     (rsp_data),
        .rsp_valid    (rsp_valid),
        .sample_data  (sample_data),
        .sample_valid (sample_valid),
        .sample_ready (sample_ready)
    );

    ads_spi_master spi_i (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_last  (tx_last),
        .tx_ready (tx_ready),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .sclk     (sclk),
        .mosi     (mosi),
        .cs_n     (cs_n),
        .miso     (miso)
    );

endmodule

/* tests/ads_top_chk.sv */
// Protocol checks for the ADS124x controller top level
// Bound into ads_top; counts assertion failures for the testbench

`timescale 1ns/1ns

module ads_top_chk (
    input logic aclk,
    input logic aresetn,
    input logic cs_n,
    input logic sclk,
    input logic sample_valid,
    input logic sample_ready,
    input logic op_auto,
    input logic adc_start,
    input logic adc_reset_n
);

    int fail_cnt = 0;

    // Sample stream holds until accepted
    sample_hold_a: assert property (@(posedge aclk) disable iff (!aresetn)
        sample_valid && !sample_ready |=> sample_valid)
    else begin
        fail_cnt++;
        $error("sample_valid dropped while sample_ready was low");
    end

    // Reset puts CS high and the sample stream idle
    reset_idle_a: assert property (@(posedge aclk)
        !aresetn |=> cs_n && !sample_valid)
    else begin
        fail_cnt++;
        $error("cs_n or sample_valid wrong during reset");
    end

    // ADC pins released in auto mode
    auto_pins_a: assert property (@(posedge aclk)
        op_auto |-> adc_start && adc_reset_n)
    else begin
        fail_cnt++;
        $error("adc_start or adc_reset_n low in auto mode");
    end

    sclk_idle_a: assert property (@(posedge aclk) disable iff (!aresetn)
        cs_n |-> !sclk)
    else begin
        fail_cnt++;
        $error("sclk active while cs_n is high");
    end

endmodule

bind ads_top ads_top_chk chk_i (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .cs_n         (cs_n),
    .sclk         (sclk),
    .sample_valid (sample_valid),
    .sample_ready (sample_ready),
    .op_auto      (op_auto),
    .adc_start    (adc_start),
    .adc_reset_n  (adc_reset_n)
);

/* tests/tb_ads_top.sv */
// Testbench for the ADS124x controller top level
// SPI slave model of the ADC, manual and auto mode stimulus and value checks

`timescale 1ns/1ns

module tb_ads_top;

    localparam int clk_period  = 20;
    localparam int byte_cycles = 16 * ads_pkg::spi_half_period + 4;
    // Longest command with start and CS release slack
    localparam int cmd_limit   = 5 * byte_cycles;
    localparam int auto_limit  = ads_pkg::ticks_per_second + cmd_limit;
    // Sum of the test lengths in cycles
    localparam int run_cycles  = 2 * cmd_limit + 64 + 2 * auto_limit + cmd_limit + 32;

    logic               aclk;
    logic               aresetn;
    logic               sclk;
    logic               mosi;
    logic               miso = 1'b0;
    logic               cs_n;
    logic               adc_reset_n;
    logic               adc_start;
    logic               drdy_n;
    logic               pps;
    logic               op_auto;
    logic               man_start;
    logic               man_reset_n;
    ads_pkg::spi_word_t cmd_data;
    ads_pkg::nbytes_t   cmd_nbytes;
    logic               cmd_valid;
    logic               drdy_status;
    ads_pkg::spi_word_t rsp_data;
    logic               rsp_valid;
    ads_pkg::adc_word_t sample_data;
    logic               sample_valid;
    logic               sample_ready;

    // ADC model state
    logic [31:0] model_word;
    logic [31:0] miso_sr;
    logic [7:0]  mosi_sr;
    int          mosi_bits = 0;
    logic [7:0]  mosi_q[$];

    int seed;
    int test_errors = 0;
    int pass_count = 0;
    int fail_count = 0;
    int chk_base = 0;

    ads_top dut_i (.*);

    initial begin
        aclk = 1'b0;
        forever #(clk_period / 2) aclk = ~aclk;
    end

    // ========================================
    // ADC SPI slave model
    // ========================================

    // Reply word loaded at CS fall, shifted out on rising SCLK
    always @(negedge cs_n or posedge sclk) begin
        if (!sclk) begin
            miso_sr = model_word;
        end else if (!cs_n) begin
            miso <= miso_sr[31];
            miso_sr = {miso_sr[30:0], 1'b0};
        end
    end

    always @(negedge sclk) begin
        if (!cs_n) begin
            mosi_sr = {mosi_sr[6:0], mosi};
            mosi_bits = mosi_bits + 1;
            if (mosi_bits == 8) begin
                mosi_q.push_back(mosi_sr);
                mosi_bits = 0;
            end
        end
    end

    // ========================================
    // Helpers
    // ========================================

    task automatic step();
        @(posedge aclk);
        #2;
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        assert (actual === expected) else begin
            $display("[ERROR] %0t ns %s: expected %0h, got %0h", $time, name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic expect_true(input bit cond, input string what);
        assert (cond) else begin
            $display("%0t ns: %s", $time, what);
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        int errs;
        errs = test_errors + (dut_i.chk_i.fail_cnt - chk_base);
        if (errs == 0) begin
            pass_count++;
            $display("Test %s: no errors", name);
        end else begin
            fail_count++;
            $display("Test %s: %0d errors", name, errs);
        end
        test_errors = 0;
        chk_base = dut_i.chk_i.fail_cnt;
    endtask

    task automatic wait_bytes(input int target, input int limit);
        int n;
        n = 0;
        while (mosi_q.size() < target && n < limit) begin
            step();
            n++;
        end
        expect_true(mosi_q.size() >= target, "SPI command bytes did not arrive in time");
    endtask

    // Bytes on MOSI are the low count bytes of word, most significant first
    task automatic check_mosi(input int base, input logic [31:0] word, input int count);
        logic [7:0] exp_byte;
        expect_true(mosi_q.size() == base + count, "MOSI byte count differs from the command");
        for (int i = 0; i < count; i++) begin
            exp_byte = 8'(word >> (8 * (count - 1 - i)));
            if (base + i < mosi_q.size()) begin
                check_value($sformatf("mosi byte %0d", i), 64'(mosi_q[base + i]),
                            64'(exp_byte));
            end
        end
    endtask

    task automatic wait_drdy_status(input logic level);
        int n;
        n = 0;
        while (drdy_status !== level && n < 16) begin
            step();
            n++;
        end
        expect_true(drdy_status === level, "drdy_status did not follow drdy_n");
    endtask

    task automatic send_command(input ads_pkg::nbytes_t nb);
        int          base;
        int          n;
        logic [31:0] exp_rsp;
        model_word = $random(seed);
        base       = mosi_q.size();
        cmd_data   = $random(seed);
        cmd_nbytes = nb;
        cmd_valid  = 1'b1;
        step();
        cmd_valid = 1'b0;
        check_value("rsp_valid", 64'(rsp_valid), 64'd0);
        check_value("rsp_data", 64'(rsp_data), 64'd0);
        n = 0;
        while (!rsp_valid && n < cmd_limit) begin
            step();
            n++;
        end
        expect_true(rsp_valid, "no response to the manual command");
        // Reply is the top bytes of the model word, right-aligned
        exp_rsp = model_word >> (8 * (3 - int'(nb)));
        check_value("rsp_data", 64'(rsp_data), 64'(exp_rsp));
        check_mosi(base, cmd_data, int'(nb) + 1);
    endtask

    // ========================================
    // Stimulus
    // ========================================

    initial begin
        int                 base;
        int                 n;
        ads_pkg::adc_word_t held;
        seed         = 32'hdd4e7804;
        aresetn      = 1'b0;
        drdy_n       = 1'b1;
        pps          = 1'b0;
        op_auto      = 1'b0;
        man_start    = 1'b0;
        man_reset_n  = 1'b1;
        cmd_data     = '0;
        cmd_nbytes   = '0;
        cmd_valid    = 1'b0;
        sample_ready = 1'b0;
        model_word   = '0;
        repeat (3) @(posedge aclk);
        #2;
        aresetn = 1'b1;
        step();

        send_command(2'd3);
        send_command(2'd1);
        finish_test("manual command");

        man_start   = 1'b1;
        man_reset_n = 1'b0;
        step();
        check_value("adc_start", 64'(adc_start), 64'd1);
        check_value("adc_reset_n", 64'(adc_reset_n), 64'd0);
        man_start   = 1'b0;
        man_reset_n = 1'b1;
        step();
        check_value("adc_start", 64'(adc_start), 64'd0);
        check_value("adc_reset_n", 64'(adc_reset_n), 64'd1);
        drdy_n = 1'b0;
        wait_drdy_status(1'b0);
        drdy_n = 1'b1;
        wait_drdy_status(1'b1);
        finish_test("manual pin control");

        // PPS restarts the second, channel 0 then channel 1 MUX writes
        base    = mosi_q.size();
        op_auto = 1'b1;
        pps     = 1'b1;
        step();
        pps = 1'b0;
        wait_bytes(base + 3, auto_limit);
        check_mosi(base, 32'h00400017, 3);
        base = mosi_q.size();
        wait_bytes(base + 3, auto_limit);
        check_mosi(base, 32'h00400008, 3);
        finish_test("auto mux writes");

        // DRDY falls while waiting on channel 1
        model_word = $random(seed);
        base       = mosi_q.size();
        drdy_n     = 1'b0;
        repeat (4) step();
        drdy_n = 1'b1;
        n = 0;
        while (!sample_valid && n < cmd_limit) begin
            step();
            n++;
        end
        expect_true(sample_valid, "no sample after the DRDY falling edge");
        check_mosi(base, 32'h00FFFFFF, 3);
        check_value("sample_data[31:0]", 64'(sample_data[31:0]),
                    64'({8'h00, model_word[31:8]}));
        expect_true(int'(sample_data[55:32]) >= ads_pkg::ticks_per_second / 2 &&
                    int'(sample_data[55:32]) < ads_pkg::ticks_per_second,
                    "sample timestamp is not in the second half of the current second");
        finish_test("auto sample read");

        held = sample_data;
        repeat (16) begin
            step();
            check_value("sample_valid", 64'(sample_valid), 64'd1);
            check_value("sample_data", 64'(sample_data), 64'(held));
        end
        sample_ready = 1'b1;
        step();
        check_value("sample_valid", 64'(sample_valid), 64'd0);
        op_auto = 1'b0;
        finish_test("sample back-pressure");

        $display("Summary: %0d tests passed, %0d tests failed, %0d assertion failures",
                 pass_count, fail_count, dut_i.chk_i.fail_cnt);
        if (fail_count == 0 && dut_i.chk_i.fail_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog at 1.5 times the summed test lengths
    initial begin
        #(run_cycles * 3 / 2 * clk_period);
        $display("Watchdog: the run timed out after %0d ns", run_cycles * 3 / 2 * clk_period);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* verilog.f */
verilog/ads_pkg.sv
verilog/ads_pps_timer.sv
verilog/ads_spi_master.sv
verilog/ads_ctrl.sv
verilog/ads_top.sv
tests/ads_top_chk.sv
tests/tb_ads_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the ADS124x controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing --timescale 1ns/1ns \
    --top-module tb_ads_top -f verilog.f -o tb_ads_top

./obj_dir/tb_ads_top +verilator+error+limit+1000 | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    echo "Simulation failed"
    exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"
